// ==== branch_stack/branch_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_stack (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  push,
    input  rename_pkg::b_mask_t   push_tag,
    input  rename_pkg::b_mask_t   push_deps,
    input  rename_pkg::addr_t     push_pc,
    input  rename_pkg::rob_idx_t  push_rob_tail,
    input  rename_pkg::map_snap_t map_snap,
    input  rename_pkg::free_vec_t free_snap,
    input  rename_pkg::resolve_t  resolve,
    output rename_pkg::restore_t  restore,
    output rename_pkg::b_mask_t   squash_tags
);
    import rename_pkg::*;

    checkpoint_t entries      [NUM_BRANCHES];
    checkpoint_t next_entries [NUM_BRANCHES];

    logic mispred;
    logic correct;

    assign mispred = resolve.valid && resolve.mispred;
    assign correct = resolve.valid && !resolve.mispred;

    // The mispredicted tag plus every younger branch that depends on it
    always_comb begin
        for (int i = 0; i < NUM_BRANCHES; i++) begin
            squash_tags[i] = mispred &&
                             (resolve.tag[i] || ((entries[i].deps & resolve.tag) != '0));
        end
    end

    // Restore packet read straight out of the tagged checkpoint
    always_comb begin
        restore = '0;
        for (int i = 0; i < NUM_BRANCHES; i++) begin
            if (mispred && resolve.tag[i]) begin
                restore.valid    = 1'b1;
                restore.pc       = entries[i].recovery_pc;
                restore.rob_tail = entries[i].rob_tail;
                restore.map      = entries[i].map;
                restore.free     = entries[i].free;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_BRANCHES; i++) begin
            next_entries[i] = entries[i];

            // Released entries drop their deps so stale bits never match a later squash
            if (squash_tags[i] || (correct && resolve.tag[i])) begin
                next_entries[i].deps = '0;
            end else if (correct) begin
                next_entries[i].deps = entries[i].deps & ~resolve.tag;
            end

            // New checkpoint lands in the slot of its own tag
            if (push && push_tag[i]) begin
                next_entries[i].recovery_pc = push_pc;
                next_entries[i].rob_tail    = push_rob_tail;
                next_entries[i].deps        = push_deps;
                next_entries[i].map         = map_snap;
                next_entries[i].free        = free_snap;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_BRANCHES; i++) begin
                entries[i].deps <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_BRANCHES; i++) begin
                entries[i] <= next_entries[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== branch_stack/branch_tag_alloc.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_tag_alloc (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                alloc,
    input  rename_pkg::resolve_t                resolve,
    input  rename_pkg::b_mask_t                 squash_tags,
    output rename_pkg::b_mask_t                 new_tag,
    output rename_pkg::b_mask_t                 cur_mask,
    output logic                                tag_free,
    output logic [rename_pkg::TAG_CNT_W-1:0]    free_tags
);
    import rename_pkg::*;

    b_mask_t busy;
    b_mask_t clear_tags;
    b_mask_t next_busy;

    logic [TAG_CNT_W-1:0] busy_count;

    // Tags released this cycle, by a correct resolve or by a squash
    assign clear_tags = squash_tags |
                        ((resolve.valid && !resolve.mispred) ? resolve.tag : '0);

    // Same-cycle dispatch already sees released tags as gone
    assign cur_mask = busy & ~clear_tags;
    assign tag_free = ~&cur_mask;

    // Lowest free tag wins, as a one-hot mask
    always_comb begin
        new_tag = '0;
        for (int i = NUM_BRANCHES - 1; i >= 0; i--) begin
            if (!cur_mask[i]) begin
                new_tag    = '0;
                new_tag[i] = 1'b1;
            end
        end
    end

    always_comb begin
        next_busy = cur_mask;
        if (alloc) begin
            next_busy = next_busy | new_tag;
        end

        busy_count = '0;
        for (int i = 0; i < NUM_BRANCHES; i++) begin
            busy_count = busy_count + TAG_CNT_W'(next_busy[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= '0;
            free_tags <= TAG_CNT_W'(NUM_BRANCHES);
        end else begin
            busy      <= next_busy;
            free_tags <= TAG_CNT_W'(NUM_BRANCHES) - busy_count;
        end
    end

endmodule

`default_nettype wire

// ==== common/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // Machine sizes
    localparam int NUM_BRANCHES  = 4;
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    localparam int ARCH_IDX_W = $clog2(NUM_ARCH_REGS);
    localparam int PHYS_IDX_W = $clog2(NUM_PHYS_REGS);
    localparam int ROB_IDX_W  = 5;
    localparam int TAG_CNT_W  = $clog2(NUM_BRANCHES + 1);

    typedef logic [ARCH_IDX_W-1:0]    arch_idx_t;
    typedef logic [PHYS_IDX_W-1:0]    phys_idx_t;
    typedef logic [31:0]              addr_t;
    typedef logic [ROB_IDX_W-1:0]     rob_idx_t;
    typedef logic [NUM_BRANCHES-1:0]  b_mask_t;
    typedef phys_idx_t [NUM_ARCH_REGS-1:0] map_snap_t;
    // A one marks a free physical register
    typedef logic [NUM_PHYS_REGS-1:0] free_vec_t;

    // dest_arch of zero means the instruction has no destination
    typedef struct packed {
        logic      valid;
        logic      is_branch;
        arch_idx_t dest_arch;
        arch_idx_t src1_arch;
        arch_idx_t src2_arch;
        addr_t     recovery_pc;
        rob_idx_t  rob_tail;
    } dispatch_req_t;

    typedef struct packed {
        logic      accept;
        phys_idx_t dest_phys;
        phys_idx_t prev_phys;
        phys_idx_t src1_phys;
        phys_idx_t src2_phys;
        b_mask_t   b_mask;
        b_mask_t   b_tag;
    } dispatch_resp_t;

    typedef struct packed {
        logic    valid;
        b_mask_t tag;
        logic    mispred;
    } resolve_t;

    typedef struct packed {
        addr_t     recovery_pc;
        rob_idx_t  rob_tail;
        b_mask_t   deps;
        map_snap_t map;
        free_vec_t free;
    } checkpoint_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        rob_idx_t  rob_tail;
        map_snap_t map;
        free_vec_t free;
    } restore_t;

    typedef struct packed {
        logic      valid;
        phys_idx_t phys;
    } retire_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the rename stage testbench with Verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f src.f --top-module rename_tb -o rename_sim \
    && ./obj_dir/rename_sim > sim.log 2>&1 \
    || echo "Build or simulation ended abnormally"

cat sim.log 2>/dev/null
grep -q 'All tests passed!' sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// ==== source/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  alloc,
    input  rename_pkg::retire_t   retire,
    input  rename_pkg::restore_t  restore,
    output rename_pkg::phys_idx_t alloc_phys,
    output logic                  has_free,
    output rename_pkg::free_vec_t snap
);
    import rename_pkg::*;

    free_vec_t free_bits;
    free_vec_t next_free;

    assign snap     = free_bits;
    assign has_free = |free_bits;

    // Priority search, lowest index first
    always_comb begin
        alloc_phys = '0;
        for (int i = NUM_PHYS_REGS - 1; i >= 0; i--) begin
            if (free_bits[i]) begin
                alloc_phys = phys_idx_t'(i);
            end
        end
    end

    always_comb begin
        next_free = free_bits;

        if (alloc) begin
            next_free[alloc_phys] = 1'b0;
        end

        // Checkpoint vector is merged, never copied over the current one
        if (restore.valid) begin
            next_free = next_free | restore.free;
        end

        if (retire.valid) begin
            next_free[retire.phys] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // Low half backs the identity map, upper half starts free
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                free_bits[i] <= (i >= NUM_ARCH_REGS);
            end
        end else begin
            free_bits <= next_free;
        end
    end

endmodule

`default_nettype wire

// ==== source/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  logic                  clock,
    input  logic                  reset,
    input  rename_pkg::arch_idx_t src1_arch,
    input  rename_pkg::arch_idx_t src2_arch,
    input  rename_pkg::arch_idx_t dest_arch,
    input  logic                  write,
    input  rename_pkg::phys_idx_t dest_phys,
    input  rename_pkg::restore_t  restore,
    output rename_pkg::phys_idx_t src1_phys,
    output rename_pkg::phys_idx_t src2_phys,
    output rename_pkg::phys_idx_t prev_phys,
    output rename_pkg::map_snap_t snap
);
    import rename_pkg::*;

    map_snap_t map;
    map_snap_t next_map;

    // Lookups see the map before this cycle's write
    assign src1_phys = map[src1_arch];
    assign src2_phys = map[src2_arch];
    assign prev_phys = map[dest_arch];

    // Whole map goes to the branch stack as a checkpoint
    assign snap = map;

    always_comb begin
        next_map = map;
        if (restore.valid) begin
            // Misprediction rolls back every mapping at once
            next_map = restore.map;
        end else if (write) begin
            next_map[dest_arch] = dest_phys;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map: arch reg i lives in phys reg i
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map[i] <= phys_idx_t'(i);
            end
        end else begin
            map <= next_map;
        end
    end

endmodule

`default_nettype wire

// ==== source/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_top (
    input  logic                             clock,
    input  logic                             reset,
    input  rename_pkg::dispatch_req_t        req,
    input  rename_pkg::resolve_t             resolve,
    input  rename_pkg::retire_t              retire,
    output rename_pkg::dispatch_resp_t       resp,
    output logic                             stall,
    output logic                             restore_valid,
    output rename_pkg::addr_t                restore_pc,
    output rename_pkg::rob_idx_t             restore_rob_tail,
    output logic [rename_pkg::TAG_CNT_W-1:0] free_tags
);
    import rename_pkg::*;

    b_mask_t   new_tag;
    b_mask_t   cur_mask;
    b_mask_t   squash_tags;
    logic      tag_free;
    logic      has_free;
    logic      needs_dest;
    logic      accept;
    logic      alloc_reg;
    logic      push_branch;
    phys_idx_t alloc_phys;
    phys_idx_t src1_phys;
    phys_idx_t src2_phys;
    phys_idx_t prev_phys;
    map_snap_t map_snap;
    free_vec_t free_snap;
    restore_t  restore;

    // Branches never write a register, so only plain ops with a dest need one
    assign needs_dest = !req.is_branch && (req.dest_arch != '0);

    assign stall = req.valid &&
                   ((needs_dest && !has_free) || (req.is_branch && !tag_free));

    // A misprediction in flight drops this cycle's dispatch
    assign accept      = req.valid && !restore.valid && !stall;
    assign alloc_reg   = accept && needs_dest;
    assign push_branch = accept && req.is_branch;

    always_comb begin
        resp           = '0;
        resp.accept    = accept;
        resp.dest_phys = needs_dest ? alloc_phys : '0;
        resp.prev_phys = needs_dest ? prev_phys : '0;
        resp.src1_phys = src1_phys;
        resp.src2_phys = src2_phys;
        resp.b_mask    = cur_mask;
        resp.b_tag     = req.is_branch ? new_tag : '0;
    end

    assign restore_valid    = restore.valid;
    assign restore_pc       = restore.pc;
    assign restore_rob_tail = restore.rob_tail;

    branch_tag_alloc branch_tag_alloc_inst (
        .clock       (clock),
        .reset       (reset),
        .alloc       (push_branch),
        .resolve     (resolve),
        .squash_tags (squash_tags),
        .new_tag     (new_tag),
        .cur_mask    (cur_mask),
        .tag_free    (tag_free),
        .free_tags   (free_tags)
    );

    branch_stack branch_stack_inst (
        .clock         (clock),
        .reset         (reset),
        .push          (push_branch),
        .push_tag      (new_tag),
        .push_deps     (cur_mask),
        .push_pc       (req.recovery_pc),
        .push_rob_tail (req.rob_tail),
        .map_snap      (map_snap),
        .free_snap     (free_snap),
        .resolve       (resolve),
        .restore       (restore),
        .squash_tags   (squash_tags)
    );

    map_table map_table_inst (
        .clock     (clock),
        .reset     (reset),
        .src1_arch (req.src1_arch),
        .src2_arch (req.src2_arch),
        .dest_arch (req.dest_arch),
        .write     (alloc_reg),
        .dest_phys (alloc_phys),
        .restore   (restore),
        .src1_phys (src1_phys),
        .src2_phys (src2_phys),
        .prev_phys (prev_phys),
        .snap      (map_snap)
    );

    free_list free_list_inst (
        .clock      (clock),
        .reset      (reset),
        .alloc      (alloc_reg),
        .retire     (retire),
        .restore    (restore),
        .alloc_phys (alloc_phys),
        .has_free   (has_free),
        .snap       (free_snap)
    );

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+test
common/rename_pkg.sv
branch_stack/branch_tag_alloc.sv
branch_stack/branch_stack.sv
source/map_table.sv
source/free_list.sv
source/rename_top.sv
test/rename_tb.sv

// ==== test/rename_model.svh ====
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// Reference state of the rename stage, stepped once per clock edge
phys_idx_t ref_map [NUM_ARCH_REGS];
free_vec_t ref_free;
b_mask_t   ref_busy;
addr_t     cp_pc   [NUM_BRANCHES];
rob_idx_t  cp_rob  [NUM_BRANCHES];
b_mask_t   cp_deps [NUM_BRANCHES];
phys_idx_t cp_map  [NUM_BRANCHES][NUM_ARCH_REGS];
free_vec_t cp_free [NUM_BRANCHES];

// Expected outputs for the inputs driven in the current cycle
dispatch_resp_t       exp_resp;
logic                 exp_stall;
logic                 exp_restore_valid;
addr_t                exp_restore_pc;
rob_idx_t             exp_restore_rob_tail;
logic [TAG_CNT_W-1:0] exp_free_tags;
logic                 dest_needed;
b_mask_t              released;
int                   mispred_idx;

task automatic reset_model();
    for (int i = 0; i < NUM_ARCH_REGS; i++)
        ref_map[i] = phys_idx_t'(i);
    ref_free = {{(NUM_PHYS_REGS - NUM_ARCH_REGS){1'b1}}, {NUM_ARCH_REGS{1'b0}}};
    ref_busy = '0;
    for (int i = 0; i < NUM_BRANCHES; i++)
        cp_deps[i] = '0;
endtask

task automatic predict(input dispatch_req_t rq, input resolve_t rs);
    b_mask_t live;
    int      tag_idx;

    tag_idx     = 0;
    mispred_idx = -1;
    released    = '0;
    for (int i = 0; i < NUM_BRANCHES; i++)
        if (rs.tag[i])
            tag_idx = i;
    if (rs.valid && rs.mispred) begin
        mispred_idx = tag_idx;
        // The branch itself and every outstanding branch that depends on it
        for (int i = 0; i < NUM_BRANCHES; i++)
            released[i] = (i == tag_idx) || (ref_busy[i] && cp_deps[i][tag_idx]);
    end else if (rs.valid) begin
        released[tag_idx] = 1'b1;
    end
    live = ref_busy & ~released;

    dest_needed = !rq.is_branch && (rq.dest_arch != '0);
    exp_stall   = rq.valid && ((dest_needed && ref_free == '0) || (rq.is_branch && &live));
    exp_restore_valid    = (mispred_idx >= 0);
    exp_restore_pc       = exp_restore_valid ? cp_pc[tag_idx] : '0;
    exp_restore_rob_tail = exp_restore_valid ? cp_rob[tag_idx] : '0;

    exp_resp        = '0;
    exp_resp.accept = rq.valid && !exp_restore_valid && !exp_stall;
    // Lowest free register and lowest free tag
    for (int i = NUM_PHYS_REGS - 1; i >= 0; i--)
        if (dest_needed && ref_free[i])
            exp_resp.dest_phys = phys_idx_t'(i);
    for (int i = NUM_BRANCHES - 1; i >= 0; i--)
        if (rq.is_branch && !live[i])
            exp_resp.b_tag = b_mask_t'(1) << i;
    exp_resp.prev_phys = dest_needed ? ref_map[rq.dest_arch] : '0;
    exp_resp.src1_phys = ref_map[rq.src1_arch];
    exp_resp.src2_phys = ref_map[rq.src2_arch];
    exp_resp.b_mask    = live;
    exp_free_tags      = TAG_CNT_W'(NUM_BRANCHES - $countones(ref_busy));
endtask

task automatic update_model(input dispatch_req_t rq, input resolve_t rs, input retire_t rt);
    // Releases first, a new checkpoint may then take a freed slot
    for (int i = 0; i < NUM_BRANCHES; i++) begin
        if (released[i])
            cp_deps[i] = '0;
        else if (rs.valid && !rs.mispred)
            cp_deps[i] = cp_deps[i] & ~rs.tag;
    end
    ref_busy = ref_busy & ~released;
    for (int i = 0; i < NUM_BRANCHES; i++) begin
        if (exp_resp.accept && exp_resp.b_tag[i]) begin
            cp_pc[i]   = rq.recovery_pc;
            cp_rob[i]  = rq.rob_tail;
            cp_deps[i] = exp_resp.b_mask;
            cp_map[i]  = ref_map;
            cp_free[i] = ref_free;
        end
    end
    if (exp_resp.accept)
        ref_busy = ref_busy | exp_resp.b_tag;

    // Rename write, then rollback, then the retired register
    if (exp_resp.accept && dest_needed) begin
        ref_map[rq.dest_arch]        = exp_resp.dest_phys;
        ref_free[exp_resp.dest_phys] = 1'b0;
    end
    if (mispred_idx >= 0) begin
        ref_map  = cp_map[mispred_idx];
        ref_free = ref_free | cp_free[mispred_idx];
    end
    if (rt.valid)
        ref_free[rt.phys] = 1'b1;
endtask

`endif

// ==== test/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_tb;
    import rename_pkg::*;

    logic                 clock;
    logic                 reset;
    dispatch_req_t        req;
    resolve_t             resolve;
    retire_t              retire;
    dispatch_resp_t       resp;
    logic                 stall;
    logic                 restore_valid;
    addr_t                restore_pc;
    rob_idx_t             restore_rob_tail;
    logic [TAG_CNT_W-1:0] free_tags;

    int   errors        = 0;
    int   checks        = 0;
    int   tests_run     = 0;
    int   tests_failed  = 0;
    int   errors_before = 0;
    int   accepted      = 0;
    int   restores      = 0;
    logic last_stall    = 1'b0;

    `include "rename_model.svh"

    rename_top rename_top_inst (
        .clock            (clock),
        .reset            (reset),
        .req              (req),
        .resolve          (resolve),
        .retire           (retire),
        .resp             (resp),
        .stall            (stall),
        .restore_valid    (restore_valid),
        .restore_pc       (restore_pc),
        .restore_rob_tail (restore_rob_tail),
        .free_tags        (free_tags)
    );

    always #5 clock = ~clock;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        errors++;
        $display("ERR %s: got 0x%0h expected 0x%0h", name, got, want);
    endtask

    task automatic check_outputs();
        checks++;
        last_stall = stall;
        if (resp.accept)
            accepted++;
        if (restore_valid)
            restores++;
        if (resp.accept !== exp_resp.accept)
            report_mismatch("resp.accept", 64'(resp.accept), 64'(exp_resp.accept));
        if (stall !== exp_stall)
            report_mismatch("stall", 64'(stall), 64'(exp_stall));
        if (restore_valid !== exp_restore_valid)
            report_mismatch("restore_valid", 64'(restore_valid), 64'(exp_restore_valid));
        if (free_tags !== exp_free_tags)
            report_mismatch("free_tags", 64'(free_tags), 64'(exp_free_tags));
        if (exp_restore_valid && restore_pc !== exp_restore_pc)
            report_mismatch("restore_pc", 64'(restore_pc), 64'(exp_restore_pc));
        if (exp_restore_valid && restore_rob_tail !== exp_restore_rob_tail)
            report_mismatch("restore_rob_tail", 64'(restore_rob_tail),
                            64'(exp_restore_rob_tail));
        if (req.valid && resp.dest_phys !== exp_resp.dest_phys)
            report_mismatch("resp.dest_phys", 64'(resp.dest_phys), 64'(exp_resp.dest_phys));
        if (req.valid && resp.prev_phys !== exp_resp.prev_phys)
            report_mismatch("resp.prev_phys", 64'(resp.prev_phys), 64'(exp_resp.prev_phys));
        if (req.valid && resp.src1_phys !== exp_resp.src1_phys)
            report_mismatch("resp.src1_phys", 64'(resp.src1_phys), 64'(exp_resp.src1_phys));
        if (req.valid && resp.src2_phys !== exp_resp.src2_phys)
            report_mismatch("resp.src2_phys", 64'(resp.src2_phys), 64'(exp_resp.src2_phys));
        if (req.valid && resp.b_mask !== exp_resp.b_mask)
            report_mismatch("resp.b_mask", 64'(resp.b_mask), 64'(exp_resp.b_mask));
        if (req.valid && resp.b_tag !== exp_resp.b_tag)
            report_mismatch("resp.b_tag", 64'(resp.b_tag), 64'(exp_resp.b_tag));
    endtask

    // Called on a falling edge, checks just before the next rising edge
    task automatic run_cycle(input dispatch_req_t rq, input resolve_t rs, input retire_t rt);
        req     = rq;
        resolve = rs;
        retire  = rt;
        predict(rq, rs);
        #4;
        check_outputs();
        update_model(rq, rs, rt);
        @(negedge clock);
    endtask

    function automatic dispatch_req_t make_plain();
        dispatch_req_t r;
        r             = '0;
        r.valid       = 1'b1;
        r.dest_arch   = arch_idx_t'($urandom);
        r.src1_arch   = arch_idx_t'($urandom);
        r.src2_arch   = arch_idx_t'($urandom);
        r.recovery_pc = $urandom;
        r.rob_tail    = rob_idx_t'($urandom);
        return r;
    endfunction

    function automatic dispatch_req_t make_branch();
        dispatch_req_t r;
        r           = make_plain();
        r.is_branch = 1'b1;
        r.dest_arch = '0;
        return r;
    endfunction

    // Random register that the model holds as in use, none if all are free
    function automatic retire_t pick_retire();
        retire_t r;
        int      start;
        r     = '0;
        start = $urandom_range(NUM_PHYS_REGS - 1);
        for (int i = 0; i < NUM_PHYS_REGS; i++) begin
            if (!r.valid && !ref_free[(start + i) % NUM_PHYS_REGS]) begin
                r.valid = 1'b1;
                r.phys  = phys_idx_t'((start + i) % NUM_PHYS_REGS);
            end
        end
        return r;
    endfunction

    // Random outstanding branch, none if no tag is busy
    function automatic resolve_t pick_resolve(input logic mispred);
        resolve_t r;
        int       start;
        r     = '0;
        start = $urandom_range(NUM_BRANCHES - 1);
        for (int i = 0; i < NUM_BRANCHES; i++) begin
            if (!r.valid && ref_busy[(start + i) % NUM_BRANCHES]) begin
                r.valid                           = 1'b1;
                r.mispred                         = mispred;
                r.tag[(start + i) % NUM_BRANCHES] = 1'b1;
            end
        end
        return r;
    endfunction

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d, %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d, %s: FAILED with %0d errors", tests_run, name,
                     errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        dispatch_req_t rq;
        resolve_t      rs;
        retire_t       rt;
        int            guard;
        int            pick;
        logic          saw_stall;

        void'($urandom(32'he7a4_b865));
        clock   = 1'b0;
        reset   = 1'b1;
        req     = '0;
        resolve = '0;
        retire  = '0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        reset_model();

        run_cycle('0, '0, '0);
        for (int i = 1; i <= 3; i++) begin
            rq           = make_plain();
            rq.dest_arch = arch_idx_t'(i);
            run_cycle(rq, '0, '0);
        end
        finish_test("reset state and first renames");

        saw_stall = 1'b0;
        for (int n = 0; n < 300; n++) begin
            rt = '0;
            if ($urandom_range(99) < 35)
                rt = pick_retire();
            run_cycle(make_plain(), '0, rt);
            if (last_stall)
                saw_stall = 1'b1;
        end
        if (!saw_stall) begin
            errors++;
            $display("Free list never ran empty during the random renames");
        end
        finish_test("random renames and retires");

        // Give back registers so later renames have room
        guard = 0;
        while ($countones(ref_free) < 24 && guard < NUM_PHYS_REGS) begin
            run_cycle('0, '0, pick_retire());
            guard++;
        end

        guard      = 0;
        last_stall = 1'b0;
        while (!last_stall && guard < NUM_BRANCHES + 2) begin
            run_cycle(make_plain(), '0, '0);
            run_cycle(make_branch(), '0, '0);
            guard++;
        end
        if (!last_stall) begin
            errors++;
            $display("Timed out waiting for stall with every branch tag in use");
        end
        run_cycle(make_plain(), '0, '0);
        finish_test("branch tag allocation");

        guard = 0;
        while (free_tags != TAG_CNT_W'(NUM_BRANCHES) && guard < 4 * NUM_BRANCHES) begin
            rq = '0;
            if ($urandom_range(1) == 1)
                rq = make_plain();
            run_cycle(rq, pick_resolve(1'b0), '0);
            guard++;
        end
        if (free_tags != TAG_CNT_W'(NUM_BRANCHES)) begin
            errors++;
            $display("Timed out waiting for every branch tag to be freed");
        end
        run_cycle(make_plain(), '0, '0);
        finish_test("correct resolves");

        for (int round = 0; round < 8; round++) begin
            guard = 0;
            while ($countones(ref_busy) < 3 && guard < 3 * NUM_BRANCHES) begin
                run_cycle(make_plain(), '0, pick_retire());
                run_cycle(make_branch(), '0, '0);
                guard++;
            end
            // The dispatch beside the misprediction must be dropped
            run_cycle(make_plain(), pick_resolve(1'b1), '0);
            for (int k = 0; k < 3; k++)
                run_cycle(make_plain(), '0, '0);
        end
        finish_test("mispredictions and restore");

        for (int n = 0; n < 2000; n++) begin
            rq   = '0;
            rs   = '0;
            rt   = '0;
            pick = $urandom_range(99);
            if (pick < 50)
                rq = make_plain();
            else if (pick < 70)
                rq = make_branch();
            if ($urandom_range(99) < 25)
                rs = pick_resolve($urandom_range(99) < 30);
            if ($urandom_range(99) < 40)
                rt = pick_retire();
            run_cycle(rq, rs, rt);
        end
        finish_test("long random mix");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d, accepted %0d, restores %0d",
                 tests_run, tests_failed, checks, errors, accepted, restores);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
